//--- source/rvc_pkg.sv
package rvc_pkg;

	localparam int instr_w = 32;
	localparam int cinstr_w = 16;
	localparam int reg_w = 5;

	// major opcodes, instruction bits 6..2
	typedef enum logic [4:0] {
		load      = 5'b00000,
		load_fp   = 5'b00001,
		op_imm    = 5'b00100,
		op_imm_32 = 5'b00110,
		store     = 5'b01000,
		store_fp  = 5'b01001,
		op        = 5'b01100,
		lui       = 5'b01101,
		op_32     = 5'b01110,
		branch    = 5'b11000,
		jalr      = 5'b11001,
		jal       = 5'b11011,
		system    = 5'b11100
	} opcode_t;

	localparam logic [reg_w-1:0] reg_zero = 5'd0;
	localparam logic [reg_w-1:0] reg_ra = 5'd1;
	localparam logic [reg_w-1:0] reg_sp = 5'd2;

	// 3-bit compressed register field selects x8..x15
	function automatic logic [reg_w-1:0] rvc_creg(input logic [2:0] creg);
		return {2'b01, creg};
	endfunction

	// funct3 1xx are stores, the low bits pick the fp or integer flavour
	function automatic opcode_t mem_opcode(input logic [2:0] funct3, input bit rv64);
		logic fp;
		fp = rv64 ? ~funct3[1] : funct3[0];
		if (funct3[2])
			return fp ? store_fp : store;
		return fp ? load_fp : load;
	endfunction

	// 010 for word accesses, 011 for double
	function automatic logic [2:0] mem_funct3(input logic [2:0] funct3, input bit rv64);
		return {2'b01, rv64 ? funct3[0] : ~funct3[1]};
	endfunction

	function automatic logic [instr_w-1:0] enc_r(input opcode_t opc, input logic [reg_w-1:0] rd,
		input logic [2:0] funct3, input logic [reg_w-1:0] rs1, input logic [reg_w-1:0] rs2,
		input logic [6:0] funct7);
		return {funct7, rs2, rs1, funct3, rd, opc, 2'b11};
	endfunction

	function automatic logic [instr_w-1:0] enc_i(input opcode_t opc, input logic [reg_w-1:0] rd,
		input logic [2:0] funct3, input logic [reg_w-1:0] rs1, input logic [11:0] imm);
		return {imm, rs1, funct3, rd, opc, 2'b11};
	endfunction

	function automatic logic [instr_w-1:0] enc_s(input opcode_t opc, input logic [2:0] funct3,
		input logic [reg_w-1:0] rs1, input logic [reg_w-1:0] rs2, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, funct3, imm[4:0], opc, 2'b11};
	endfunction

	// imm holds offset bits 12..1
	function automatic logic [instr_w-1:0] enc_b(input opcode_t opc, input logic [2:0] funct3,
		input logic [reg_w-1:0] rs1, input logic [reg_w-1:0] rs2, input logic [11:0] imm);
		return {imm[11], imm[9:4], rs2, rs1, funct3, imm[3:0], imm[10], opc, 2'b11};
	endfunction

	function automatic logic [instr_w-1:0] enc_u(input opcode_t opc, input logic [reg_w-1:0] rd,
		input logic [19:0] imm);
		return {imm, rd, opc, 2'b11};
	endfunction

	// imm holds offset bits 20..1
	function automatic logic [instr_w-1:0] enc_j(input opcode_t opc, input logic [reg_w-1:0] rd,
		input logic [19:0] imm);
		return {imm[19], imm[9:0], imm[10], imm[18:11], rd, opc, 2'b11};
	endfunction

endpackage

//--- source/rvc_quadrant0.sv
`timescale 1ns/100ps

module rvc_quadrant0 import rvc_pkg::*; #(
	parameter bit rv64 = 1'b1
) (
	input  logic [cinstr_w-1:0] cinstr_i,
	output logic [instr_w-1:0]  instr_o,
	output logic                illegal_o
);

	logic [2:0] f3;
	logic [2:0] width_f3;
	logic dbl;
	logic [11:0] imm_4spn;
	logic [11:0] imm_mem;

	assign f3 = cinstr_i[15:13];
	assign width_f3 = mem_funct3(f3, rv64);
	assign dbl = width_f3[0];

	assign imm_4spn = {2'b00, cinstr_i[10:7], cinstr_i[12:11], cinstr_i[5], cinstr_i[6], 2'b00};

	// bit 6 of the halfword lands on offset bit 7 or bit 2 depending on access size
	assign imm_mem = {4'b0000, dbl & cinstr_i[6], cinstr_i[5], cinstr_i[12:10],
		~dbl & cinstr_i[6], 2'b00};

	always_comb begin
		instr_o = '0;
		illegal_o = 1'b0;
		case (f3)
			3'b000: begin
				if (cinstr_i == '0)
					illegal_o = 1'b1;
				else
					instr_o = enc_i(op_imm, rvc_creg(cinstr_i[4:2]), 3'b000, reg_sp, imm_4spn);
			end
			3'b001, 3'b010, 3'b011:
				instr_o = enc_i(mem_opcode(f3, rv64), rvc_creg(cinstr_i[4:2]), width_f3,
					rvc_creg(cinstr_i[9:7]), imm_mem);
			3'b100:
				illegal_o = 1'b1;
			default:
				instr_o = enc_s(mem_opcode(f3, rv64), width_f3, rvc_creg(cinstr_i[9:7]),
					rvc_creg(cinstr_i[4:2]), imm_mem);
		endcase
	end

endmodule

//--- source/rvc_quadrant1.sv
`timescale 1ns/100ps

module rvc_quadrant1 import rvc_pkg::*; #(
	parameter bit rv64 = 1'b1
) (
	input  logic [cinstr_w-1:0] cinstr_i,
	output logic [instr_w-1:0]  instr_o,
	output logic                illegal_o
);

	logic [2:0] f3;
	logic [reg_w-1:0] rd;
	logic [reg_w-1:0] rd_c;
	logic [reg_w-1:0] rs2_c;
	logic [11:0] imm_i;
	logic [11:0] imm_shamt;
	logic [11:0] imm_sp16;
	logic [19:0] imm_u;
	logic [19:0] imm_j;
	logic [11:0] imm_b;
	logic [2:0] alu_f3;
	logic [6:0] alu_f7;

	assign f3 = cinstr_i[15:13];
	assign rd = cinstr_i[11:7];
	assign rd_c = rvc_creg(cinstr_i[9:7]);
	assign rs2_c = rvc_creg(cinstr_i[4:2]);

	assign imm_i = {{6{cinstr_i[12]}}, cinstr_i[12], cinstr_i[6:2]};
	assign imm_u = {{14{cinstr_i[12]}}, cinstr_i[12], cinstr_i[6:2]};

	// bit 10 of the halfword sets the arithmetic shift
	assign imm_shamt = {1'b0, cinstr_i[10], 4'b0000, cinstr_i[12], cinstr_i[6:2]};

	assign imm_sp16 = {{3{cinstr_i[12]}}, cinstr_i[4:3], cinstr_i[5], cinstr_i[2], cinstr_i[6],
		4'b0000};

	// offset bits 11..1, sign extended
	assign imm_j = {{9{cinstr_i[12]}}, cinstr_i[12], cinstr_i[8], cinstr_i[10:9], cinstr_i[6],
		cinstr_i[7], cinstr_i[2], cinstr_i[11], cinstr_i[5:3]};

	// offset bits 8..1, sign extended
	assign imm_b = {{4{cinstr_i[12]}}, cinstr_i[12], cinstr_i[6:5], cinstr_i[2], cinstr_i[11:10],
		cinstr_i[4:3]};

	// sub xor or and
	assign alu_f3 = {|cinstr_i[6:5], cinstr_i[6], &cinstr_i[6:5]};
	assign alu_f7 = {1'b0, ~|cinstr_i[6:5], 5'b00000};

	always_comb begin
		instr_o = '0;
		illegal_o = 1'b0;
		case (f3)
			3'b000:
				instr_o = enc_i(op_imm, rd, 3'b000, rd, imm_i);
			3'b001: begin
				if (rv64)
					instr_o = enc_i(op_imm_32, rd, 3'b000, rd, imm_i);
				else
					instr_o = enc_j(jal, reg_ra, imm_j);
			end
			3'b010:
				instr_o = enc_i(op_imm, rd, 3'b000, reg_zero, imm_i);
			3'b011: begin
				if (rd == reg_sp)
					instr_o = enc_i(op_imm, reg_sp, 3'b000, reg_sp, imm_sp16);
				else
					instr_o = enc_u(lui, rd, imm_u);
			end
			3'b100: begin
				case (cinstr_i[11:10])
					2'b00, 2'b01:
						instr_o = enc_i(op_imm, rd_c, 3'b101, rd_c, imm_shamt);
					2'b10:
						instr_o = enc_i(op_imm, rd_c, 3'b111, rd_c, imm_i);
					default: begin
						if (!cinstr_i[12])
							instr_o = enc_r(op, rd_c, alu_f3, rd_c, rs2_c, alu_f7);
						else if (rv64 && !cinstr_i[6])
							instr_o = enc_r(op_32, rd_c, 3'b000, rd_c, rs2_c,
								{1'b0, ~cinstr_i[5], 5'b00000});
						else
							illegal_o = 1'b1;
					end
				endcase
			end
			3'b101:
				instr_o = enc_j(jal, reg_zero, imm_j);
			default:
				instr_o = enc_b(branch, {2'b00, f3[0]}, rd_c, reg_zero, imm_b);
		endcase
	end

endmodule

//--- source/rvc_quadrant2.sv
`timescale 1ns/100ps

module rvc_quadrant2 import rvc_pkg::*; #(
	parameter bit rv64 = 1'b1
) (
	input  logic [cinstr_w-1:0] cinstr_i,
	output logic [instr_w-1:0]  instr_o,
	output logic                illegal_o
);

	logic [2:0] f3;
	logic [2:0] width_f3;
	logic dbl;
	logic [reg_w-1:0] rd;
	logic [reg_w-1:0] rs2;
	logic [11:0] imm_slli;
	logic [11:0] imm_lsp;
	logic [11:0] imm_ssp;

	assign f3 = cinstr_i[15:13];
	assign width_f3 = mem_funct3(f3, rv64);
	assign dbl = width_f3[0];
	assign rd = cinstr_i[11:7];
	assign rs2 = cinstr_i[6:2];

	assign imm_slli = {6'b000000, cinstr_i[12], cinstr_i[6:2]};

	// sp offsets are zero extended
	assign imm_lsp = {3'b000, dbl & cinstr_i[4], cinstr_i[3:2], cinstr_i[12], cinstr_i[6:5],
		~dbl & cinstr_i[4], 2'b00};
	assign imm_ssp = {3'b000, dbl & cinstr_i[9], cinstr_i[8:7], cinstr_i[12:10],
		~dbl & cinstr_i[9], 2'b00};

	always_comb begin
		instr_o = '0;
		illegal_o = 1'b0;
		case (f3)
			3'b000:
				instr_o = enc_i(op_imm, rd, 3'b001, rd, imm_slli);
			3'b001, 3'b010, 3'b011:
				instr_o = enc_i(mem_opcode(f3, rv64), rd, width_f3, reg_sp, imm_lsp);
			3'b100: begin
				if (rd == reg_zero && rs2 != reg_zero)
					illegal_o = 1'b1;
				else if (!cinstr_i[12] && rs2 == reg_zero)
					instr_o = enc_i(jalr, reg_zero, 3'b000, rd, 12'h000);
				else if (!cinstr_i[12])
					instr_o = enc_r(op, rd, 3'b000, reg_zero, rs2, 7'b0000000);
				else if (rd == reg_zero)
					instr_o = enc_i(system, reg_zero, 3'b000, reg_zero, 12'h001);
				else if (rs2 == reg_zero)
					instr_o = enc_i(jalr, reg_ra, 3'b000, rd, 12'h000);
				else
					instr_o = enc_r(op, rd, 3'b000, rd, rs2, 7'b0000000);
			end
			default:
				instr_o = enc_s(mem_opcode(f3, rv64), width_f3, reg_sp, rs2, imm_ssp);
		endcase
	end

endmodule

//--- source/rvc_expander.sv
`timescale 1ns/100ps

module rvc_expander import rvc_pkg::*; #(
	parameter bit rv64 = 1'b1
) (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               valid_i,
	input  logic [instr_w-1:0] instr_i,
	output logic               valid_o,
	output logic [instr_w-1:0] instr_o,
	output logic               illegal_o,
	output logic               compressed_o
);

	logic [instr_w-1:0] q0_instr;
	logic [instr_w-1:0] q1_instr;
	logic [instr_w-1:0] q2_instr;
	logic q0_illegal;
	logic q1_illegal;
	logic q2_illegal;
	logic [instr_w-1:0] sel_instr;
	logic sel_illegal;
	logic [instr_w-1:0] nxt_instr;
	logic nxt_compressed;

	rvc_quadrant0 #(.rv64(rv64)) u_rvc_quadrant0 (
		.cinstr_i  (instr_i[cinstr_w-1:0]),
		.instr_o   (q0_instr),
		.illegal_o (q0_illegal)
	);

	rvc_quadrant1 #(.rv64(rv64)) u_rvc_quadrant1 (
		.cinstr_i  (instr_i[cinstr_w-1:0]),
		.instr_o   (q1_instr),
		.illegal_o (q1_illegal)
	);

	rvc_quadrant2 #(.rv64(rv64)) u_rvc_quadrant2 (
		.cinstr_i  (instr_i[cinstr_w-1:0]),
		.instr_o   (q2_instr),
		.illegal_o (q2_illegal)
	);

	always_comb begin
		case (instr_i[1:0])
			2'b00: begin
				sel_instr = q0_instr;
				sel_illegal = q0_illegal;
			end
			2'b01: begin
				sel_instr = q1_instr;
				sel_illegal = q1_illegal;
			end
			2'b10: begin
				sel_instr = q2_instr;
				sel_illegal = q2_illegal;
			end
			default: begin
				// full-width word, untouched
				sel_instr = instr_i;
				sel_illegal = 1'b0;
			end
		endcase
	end

	assign nxt_instr = sel_illegal ? '0 : sel_instr;
	assign nxt_compressed = ~&instr_i[1:0];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
			instr_o <= '0;
			illegal_o <= 1'b0;
			compressed_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
			// hold the last result between strobes
			if (valid_i) begin
				instr_o <= nxt_instr;
				illegal_o <= sel_illegal;
				compressed_o <= nxt_compressed;
			end
		end
	end

endmodule

//--- sim/rvc_expander_assertions.sv
`timescale 1ns/100ps

module rvc_expander_assertions import rvc_pkg::*; (
	input logic               clk_i,
	input logic               rst_n_i,
	input logic               valid_i,
	input logic               valid_o,
	input logic               illegal_o,
	input logic [instr_w-1:0] instr_o
);

	int fail_count = 0;

	a_reset_clears: assert property (@(posedge clk_i) !rst_n_i |=> !valid_o)
	else begin
		$error("valid_o high in the cycle after reset");
		fail_count++;
	end

	// one register stage between strobe in and strobe out
	a_valid_delay: assert property (@(posedge clk_i) rst_n_i |=> valid_o == $past(valid_i))
	else begin
		$error("valid_o does not follow valid_i by one cycle");
		fail_count++;
	end

	a_illegal_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		illegal_o |-> instr_o == '0)
	else begin
		$error("illegal_o high with a nonzero instr_o");
		fail_count++;
	end

endmodule

bind rvc_expander rvc_expander_assertions u_rvc_expander_assertions (
	.clk_i     (clk_i),
	.rst_n_i   (rst_n_i),
	.valid_i   (valid_i),
	.valid_o   (valid_o),
	.illegal_o (illegal_o),
	.instr_o   (instr_o)
);

//--- sim/rvc_expander_tb.sv
`timescale 1ns/100ps

module rvc_expander_tb import rvc_pkg::*; #(
	parameter bit rv64 = 1'b1
);

	localparam int clk_period = 40;
	localparam int reset_cycles = 5;
	localparam int idle_cycles = 4;
	localparam int n_pass = 100;
	localparam int n_quad = 400;
	localparam int n_illegal = 60;
	localparam int n_total = reset_cycles + idle_cycles + 1 + n_pass + 3 * n_quad + n_illegal;

	logic clk = 1'b0;
	logic rst_n;
	logic valid_in;
	logic [instr_w-1:0] instr_in;
	logic valid_out;
	logic [instr_w-1:0] instr_out;
	logic illegal_out;
	logic compressed_out;

	integer seed = 32'h8a67;
	int cyc = 0;
	bit reset_phase = 1'b1;
	// {compressed, illegal, instruction}
	logic [33:0] exp_q[$];
	int stamp_q[$];
	string name_q[$];

	rvc_expander #(.rv64(rv64)) u_rvc_expander (
		.clk_i        (clk),
		.rst_n_i      (rst_n),
		.valid_i      (valid_in),
		.instr_i      (instr_in),
		.valid_o      (valid_out),
		.instr_o      (instr_out),
		.illegal_o    (illegal_out),
		.compressed_o (compressed_out)
	);

	always #(clk_period / 2) clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	function automatic logic [33:0] ref_expand(input logic [31:0] w);
		logic [15:0] c;
		logic [31:0] r;
		logic ill;
		logic [4:0] rd;
		logic [4:0] rs2;
		logic [4:0] rdp;
		logic [4:0] rsp;
		logic [2:0] f3;
		logic dbl;
		logic fp;
		logic [11:0] imm6;
		logic [11:0] mimm;
		logic [20:0] joff;
		logic [12:0] boff;
		c = w[15:0];
		r = '0;
		ill = 1'b0;
		rd = c[11:7];
		rs2 = c[6:2];
		rdp = {2'b01, c[9:7]};
		rsp = {2'b01, c[4:2]};
		f3 = c[15:13];
		// fld/fsd are always double and funct3 x11 is ld/sd only on rv64
		dbl = (f3[1:0] == 2'b01) || (rv64 && f3[1:0] == 2'b11);
		fp = (f3[1:0] == 2'b01) || (!rv64 && f3[1:0] == 2'b11);
		imm6 = {{6{c[12]}}, c[12], c[6:2]};
		joff = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
		boff = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
		case (c[1:0])
			2'b00: begin
				if (dbl)
					mimm = {4'b0000, c[6:5], c[12:10], 3'b000};
				else
					mimm = {5'b00000, c[5], c[12:10], c[6], 2'b00};
				if (c == '0 || f3 == 3'b100)
					ill = 1'b1;
				else if (f3 == 3'b000)
					r = enc_i(op_imm, rsp, 3'b000, reg_sp,
						{2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00});
				else if (!f3[2])
					r = enc_i(fp ? load_fp : load, rsp, {2'b01, dbl}, rdp, mimm);
				else
					r = enc_s(fp ? store_fp : store, {2'b01, dbl}, rdp, rsp, mimm);
			end
			2'b01: begin
				case (f3)
					3'b000: r = enc_i(op_imm, rd, 3'b000, rd, imm6);
					3'b001: r = rv64 ? enc_i(op_imm_32, rd, 3'b000, rd, imm6)
						: enc_j(jal, reg_ra, joff[20:1]);
					3'b010: r = enc_i(op_imm, rd, 3'b000, reg_zero, imm6);
					3'b011: begin
						if (rd == reg_sp)
							r = enc_i(op_imm, reg_sp, 3'b000, reg_sp,
								{{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000});
						else
							r = enc_u(lui, rd, {{14{c[12]}}, c[12], c[6:2]});
					end
					3'b100: begin
						case (c[11:10])
							2'b00: r = enc_i(op_imm, rdp, 3'b101, rdp, {6'b000000, c[12], c[6:2]});
							2'b01: r = enc_i(op_imm, rdp, 3'b101, rdp, {6'b010000, c[12], c[6:2]});
							2'b10: r = enc_i(op_imm, rdp, 3'b111, rdp, imm6);
							default: begin
								if (c[12] && !(rv64 && !c[6]))
									ill = 1'b1;
								else if (c[12])
									r = enc_r(op_32, rdp, 3'b000, rdp, rsp, c[5] ? 7'h00 : 7'h20);
								else if (c[6:5] == 2'b00)
									r = enc_r(op, rdp, 3'b000, rdp, rsp, 7'h20);
								else
									r = enc_r(op, rdp, {1'b1, c[6], c[6] & c[5]}, rdp, rsp, 7'h00);
							end
						endcase
					end
					3'b101: r = enc_j(jal, reg_zero, joff[20:1]);
					default: r = enc_b(branch, {2'b00, f3[0]}, rdp, reg_zero, boff[12:1]);
				endcase
			end
			2'b10: begin
				case (f3)
					3'b000: r = enc_i(op_imm, rd, 3'b001, rd, {6'b000000, c[12], c[6:2]});
					3'b100: begin
						if (rd == reg_zero && rs2 != reg_zero)
							ill = 1'b1;
						else if (rd == reg_zero && c[12])
							r = enc_i(system, reg_zero, 3'b000, reg_zero, 12'h001);
						else if (rs2 == reg_zero)
							r = enc_i(jalr, c[12] ? reg_ra : reg_zero, 3'b000, rd, 12'h000);
						else
							r = enc_r(op, rd, 3'b000, c[12] ? rd : reg_zero, rs2, 7'h00);
					end
					3'b001, 3'b010, 3'b011: begin
						if (dbl)
							mimm = {3'b000, c[4:2], c[12], c[6:5], 3'b000};
						else
							mimm = {4'b0000, c[3:2], c[12], c[6:4], 2'b00};
						r = enc_i(fp ? load_fp : load, rd, {2'b01, dbl}, reg_sp, mimm);
					end
					default: begin
						if (dbl)
							mimm = {3'b000, c[9:7], c[12:10], 3'b000};
						else
							mimm = {4'b0000, c[8:7], c[12:9], 2'b00};
						r = enc_s(fp ? store_fp : store, {2'b01, dbl}, reg_sp, rs2, mimm);
					end
				endcase
			end
			default: r = w;
		endcase
		return {c[1:0] != 2'b11, ill, r};
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string test, input logic [33:0] exp,
		input logic [33:0] act);
		abort_run($sformatf("Mismatch in %s: expected c=%b i=%b %h, actual c=%b i=%b %h",
			test, exp[33], exp[32], exp[31:0], act[33], act[32], act[31:0]));
	endtask

	task automatic drive(input string test, input logic [31:0] word);
		@(negedge clk);
		valid_in = 1'b1;
		instr_in = word;
		exp_q.push_back(ref_expand(word));
		stamp_q.push_back(cyc);
		name_q.push_back(test);
	endtask

	// outputs only move on the rising edge
	always @(negedge clk) begin
		logic [33:0] exp;
		string test;
		int stamp;
		assert (u_rvc_expander.u_rvc_expander_assertions.fail_count == 0)
		else abort_run("an assertion on the output register failed");
		if (reset_phase) begin
			assert (!valid_out && !illegal_out && instr_out == '0)
			else abort_run("outputs not cleared during or after reset");
		end
		if (valid_out) begin
			assert (exp_q.size() > 0)
			else abort_run("valid_o seen with no instruction outstanding");
			exp = exp_q.pop_front();
			test = name_q.pop_front();
			stamp = stamp_q.pop_front();
			assert (cyc == stamp + 1)
			else abort_run($sformatf("%s result took %0d cycles instead of 1", test, cyc - stamp));
			assert ({compressed_out, illegal_out, instr_out} === exp)
			else report_mismatch(test, exp, {compressed_out, illegal_out, instr_out});
		end
	end

	initial begin
		#((n_total + 50) * clk_period);
		$display("Timeout: not every expected result was seen in time");
		$display("Simulation failed");
		$fatal(1);
	end

	initial begin
		logic [31:0] w;
		rst_n = 1'b0;
		valid_in = 1'b0;
		instr_in = '0;
		repeat (reset_cycles) @(negedge clk);
		rst_n = 1'b1;
		repeat (idle_cycles) @(negedge clk);
		reset_phase = 1'b0;
		drive("reset", $random(seed));
		for (int i = 0; i < n_pass; i++) begin
			w = $random(seed);
			w[1:0] = 2'b11;
			drive("pass_through", w);
		end
		for (int q = 0; q < 3; q++) begin
			for (int i = 0; i < n_quad; i++) begin
				w = $random(seed);
				w[1:0] = q[1:0];
				drive($sformatf("quadrant%0d", q), w);
			end
		end
		for (int i = 0; i < n_illegal; i++) begin
			w = $random(seed);
			case (i % 5)
				0: w[15:0] = '0;
				1: w = {w[31:16], 3'b100, w[12:2], 2'b00};
				2: w = {w[31:16], 6'b100111, w[9:7], 1'b1, w[5:2], 2'b01};
				3: w = {w[31:16], 3'b100, w[12], 5'b00000, w[6:3], 1'b1, 2'b10};
				// subw and addw are illegal only on rv32
				default: w = {w[31:16], 6'b100111, w[9:7], 1'b0, w[5:2], 2'b01};
			endcase
			drive(i % 5 == 4 ? "subw_addw" : "illegal", w);
		end
		@(negedge clk);
		valid_in = 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (2) @(negedge clk);
		if (u_rvc_expander.u_rvc_expander_assertions.fail_count == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			abort_run("an assertion on the output register failed");
		end
	end

endmodule

//--- vlog.f
source/rvc_pkg.sv
source/rvc_quadrant0.sv
source/rvc_quadrant1.sv
source/rvc_quadrant2.sv
source/rvc_expander.sv
sim/rvc_expander_assertions.sv
sim/rvc_expander_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= rvc_expander_tb
RV64 ?= 1
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP RV64 BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Grv64=$(RV64) --Mdir $(BUILD_DIR) -f vlog.f
	-$(BUILD_DIR)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
